// File: common/buffer_pkg.sv
package buffer_pkg;

  // storage sizing for the FWFT FIFO and the words it carries

  // address bits of the FIFO memory
  localparam int addr_width = 4;

  // number of entries, one per address
  localparam int fifo_depth = 1 << addr_width;

  // every stored word is one byte
  localparam int data_width = 8;

  // read and write pointers carry one extra wrap bit
  localparam int ptr_width = addr_width + 1;

  // full means the wrap bits differ while the address bits match,
  // so the FIFO holds exactly fifo_depth words at that point
  localparam int full_level = fifo_depth;

endpackage

// File: common/stream_pkg.sv
package stream_pkg;

  // stream level definitions: opcodes, drain states, tag sizing

  // per-byte operation applied by the producer
  typedef enum logic [1:0] {
    op_pass   = 2'd0,
    op_invert = 2'd1,
    op_swap   = 2'd2
  } op_e;

  // drain state machine
  // drain_emit means a word was popped at the last edge
  typedef enum logic {
    drain_idle = 1'b0,
    drain_emit = 1'b1
  } drain_state_e;

  // width of the sequence tag and of the drop count
  localparam int tag_width = 4;

  // saturation value for the drop count
  localparam logic [tag_width-1:0] tag_max = {tag_width{1'b1}};

endpackage

// File: sync_fifo/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo (
  input  logic                              clk,
  input  logic                              rst_n,

  input  logic                              w_inc,
  input  logic [buffer_pkg::data_width-1:0] w_data,
  output logic                              w_full,

  input  logic                              r_inc,
  output logic                              r_empty,
  output logic [buffer_pkg::data_width-1:0] r_data
);

  logic [buffer_pkg::data_width-1:0] mem [buffer_pkg::fifo_depth];

  // pointers are one bit wider than the address
  logic [buffer_pkg::ptr_width-1:0]  w_ptr;
  logic [buffer_pkg::ptr_width-1:0]  r_ptr;

  logic [buffer_pkg::addr_width-1:0] w_addr;
  logic [buffer_pkg::addr_width-1:0] r_addr;

  logic                              do_write;
  logic                              do_read;

  assign w_addr = w_ptr[buffer_pkg::addr_width-1:0];
  assign r_addr = r_ptr[buffer_pkg::addr_width-1:0];

  // the FIFO keeps its own guards, whatever the neighbours do
  assign do_write = w_inc && !w_full;
  assign do_read  = r_inc && !r_empty;

  // storage array
  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[w_addr] <= w_data;
    end
  end

  // write pointer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_ptr <= '0;
    end else if (do_write) begin
      w_ptr <= w_ptr + 1'b1;
    end
  end

  // read pointer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_ptr <= '0;
    end else if (do_read) begin
      r_ptr <= r_ptr + 1'b1;
    end
  end

  // wrap bits differ and addresses match: every slot is in use
  assign w_full  = (w_ptr[buffer_pkg::addr_width] != r_ptr[buffer_pkg::addr_width]) &&
                   (w_addr == r_addr);
  assign r_empty = (w_ptr == r_ptr);

  // first word fall through: head word is visible without a read
  assign r_data = mem[r_addr];

endmodule

// File: hdl/word_shaper.sv
`timescale 1ns/1ps

module word_shaper (
  input  logic                              clk,
  input  logic                              rst_n,

  // byte strobe from the source
  input  logic                              in_valid,
  input  stream_pkg::op_e                   in_op,
  input  logic [buffer_pkg::data_width-1:0] in_data,

  // FIFO write side
  output logic                              w_inc,
  output logic [buffer_pkg::data_width-1:0] w_data,
  input  logic                              w_full,

  output logic                              overflow
);

  localparam int half = buffer_pkg::data_width / 2;

  logic                              pend_valid;
  logic [buffer_pkg::data_width-1:0] pend_data;
  logic [buffer_pkg::data_width-1:0] shaped;
  logic                              release_now;
  logic                              accept;

  // apply the opcode to the incoming byte
  always_comb begin
    case (in_op)
      stream_pkg::op_pass: begin
        shaped = in_data;
      end
      stream_pkg::op_invert: begin
        shaped = ~in_data;
      end
      stream_pkg::op_swap: begin
        shaped = {in_data[half-1:0], in_data[buffer_pkg::data_width-1:half]};
      end
      default: begin
        // unused encoding behaves like pass
        shaped = in_data;
      end
    endcase
  end

  // pending word leaves at the first edge with room in the FIFO
  assign release_now = pend_valid && !w_full;

  // a strobe is taken if the slot is free or frees up at this edge
  assign accept = in_valid && (!pend_valid || release_now);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_valid <= 1'b0;
      overflow   <= 1'b0;
    end else begin
      pend_valid <= accept || (pend_valid && !release_now);
      // dropped byte: one cycle pulse after the strobe
      overflow   <= in_valid && !accept;
    end
  end

  // payload only changes when a new byte is accepted
  always_ff @(posedge clk) begin
    if (accept) begin
      pend_data <= shaped;
    end
  end

  assign w_inc  = pend_valid;
  assign w_data = pend_data;

endmodule

// File: hdl/word_drain.sv
`timescale 1ns/1ps

module word_drain (
  input  logic                              clk,
  input  logic                              rst_n,

  // FIFO read side
  input  logic                              r_empty,
  input  logic [buffer_pkg::data_width-1:0] r_data,
  output logic                              r_inc,

  // downstream hold level
  input  logic                              out_hold,

  // drop pulses from the producer
  input  logic                              overflow,

  output logic                              out_valid,
  output logic [buffer_pkg::data_width-1:0] out_data,
  output logic [stream_pkg::tag_width-1:0]  out_seq,
  output logic [stream_pkg::tag_width-1:0]  drop_count
);

  stream_pkg::drain_state_e         state;
  stream_pkg::drain_state_e         state_next;

  // tag for the next word to be emitted
  logic [stream_pkg::tag_width-1:0] seq_next;

  // pop whenever there is a word and the sink is not holding
  assign r_inc = !r_empty && !out_hold;

  // emit after each pop, fall back to idle once nothing is popped
  // back-to-back pops keep the machine in emit
  always_comb begin
    state_next = r_inc ? stream_pkg::drain_emit : stream_pkg::drain_idle;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= stream_pkg::drain_idle;
    end else begin
      state <= state_next;
    end
  end

  // one pulse per popped word
  assign out_valid = (state == stream_pkg::drain_emit);

  // sequence tag wraps modulo 16
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      seq_next <= '0;
      out_seq  <= '0;
    end else if (r_inc) begin
      out_seq  <= seq_next;
      seq_next <= seq_next + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (r_inc) begin
      out_data <= r_data;
    end
  end

  // drop counter sticks at its maximum
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      drop_count <= '0;
    end else if (overflow && (drop_count != stream_pkg::tag_max)) begin
      drop_count <= drop_count + 1'b1;
    end
  end

endmodule

// File: hdl/stream_top.sv
`timescale 1ns/1ps

module stream_top (
  input  logic                              clk,
  input  logic                              rst_n,

  input  logic                              in_valid,
  input  stream_pkg::op_e                   in_op,
  input  logic [buffer_pkg::data_width-1:0] in_data,

  input  logic                              out_hold,

  output logic                              out_valid,
  output logic [buffer_pkg::data_width-1:0] out_data,
  output logic [stream_pkg::tag_width-1:0]  out_seq,
  output logic                              overflow,
  output logic [stream_pkg::tag_width-1:0]  drop_count
);

  // producer to FIFO
  logic                              w_inc;
  logic [buffer_pkg::data_width-1:0] w_data;
  logic                              w_full;

  // FIFO to consumer
  logic                              r_inc;
  logic                              r_empty;
  logic [buffer_pkg::data_width-1:0] r_data;

  word_shaper u_shaper (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_op    (in_op),
    .in_data  (in_data),
    .w_inc    (w_inc),
    .w_data   (w_data),
    .w_full   (w_full),
    .overflow (overflow)
  );

  sync_fifo u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .w_inc   (w_inc),
    .w_data  (w_data),
    .w_full  (w_full),
    .r_inc   (r_inc),
    .r_empty (r_empty),
    .r_data  (r_data)
  );

  word_drain u_drain (
    .clk        (clk),
    .rst_n      (rst_n),
    .r_empty    (r_empty),
    .r_data     (r_data),
    .r_inc      (r_inc),
    .out_hold   (out_hold),
    .overflow   (overflow),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_seq    (out_seq),
    .drop_count (drop_count)
  );

endmodule

// File: sim/stream_properties.sv
`timescale 1ns/1ps

module stream_properties (
  input logic                             clk,
  input logic                             rst_n,
  input logic                             w_full,
  input logic                             r_empty,
  input logic                             out_hold,
  input logic                             out_valid,
  input logic [stream_pkg::tag_width-1:0] drop_count
);

  // the FIFO flags exclude each other
  flags_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(w_full && r_empty)
  ) else $error("w_full and r_empty are high together");

  // first edge out of reset sees an empty FIFO
  flags_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> (r_empty && !w_full)
  ) else $error("FIFO flags are wrong right after reset");

  // a held sink gets no word in the next cycle
  hold_blocks_output: assert property (
    @(posedge clk) disable iff (!rst_n) out_valid |-> !$past(out_hold)
  ) else $error("out_valid follows a cycle with out_hold high");

  // drop count only moves up
  drop_count_monotonic: assert property (
    @(posedge clk) disable iff (!rst_n) drop_count >= $past(drop_count)
  ) else $error("drop_count decreased outside reset");

endmodule

// observes the FIFO flags and the drain outputs inside the top level
bind stream_top stream_properties u_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .w_full     (w_full),
  .r_empty    (r_empty),
  .out_hold   (out_hold),
  .out_valid  (out_valid),
  .drop_count (drop_count)
);

// File: sim/stream_tb.sv
`timescale 1ns/1ps

module stream_tb;

  localparam int timeout_cycles = 200;

  logic                              clk;
  logic                              rst_n;
  logic                              in_valid;
  stream_pkg::op_e                   in_op;
  logic [buffer_pkg::data_width-1:0] in_data;
  logic                              out_hold;
  logic                              out_valid;
  logic [buffer_pkg::data_width-1:0] out_data;
  logic [stream_pkg::tag_width-1:0]  out_seq;
  logic                              overflow;
  logic [stream_pkg::tag_width-1:0]  drop_count;

  // records taken from the golden file
  logic                              stim_valid[$];
  logic [1:0]                        stim_op[$];
  logic [buffer_pkg::data_width-1:0] stim_data[$];
  logic                              stim_hold[$];
  logic [buffer_pkg::data_width-1:0] expect_data[$];
  int                                expect_drops = 0;

  // words seen on the output side
  logic [buffer_pkg::data_width-1:0] got_data[$];
  logic [stream_pkg::tag_width-1:0]  seq_expect = '0;
  int                                overflow_seen = 0;

  int value_errors = 0;
  int timeout_errors = 0;
  int other_errors = 0;

  stream_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_data    (in_data),
    .out_hold   (out_hold),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_seq    (out_seq),
    .overflow   (overflow),
    .drop_count (drop_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_equal(input string what, input int got, input int exp);
    assert (got == exp) else begin
      $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      value_errors++;
    end
  endtask

  task automatic load_golden();
    int             fd;
    int             n;
    int             a;
    int             b;
    int             c;
    logic [7:0]     tag;
    logic [1023:0]  rest;
    fd = $fopen("sim/stream_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/stream_golden.txt");
      other_errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", tag);
      if (n != 1) break;
      if (tag == "#") begin
        n = $fgets(rest, fd);
      end else if (tag == "S") begin
        n = $fscanf(fd, "%d %h %d", a, b, c);
        stim_valid.push_back(1'b1);
        stim_op.push_back(a[1:0]);
        stim_data.push_back(b[7:0]);
        stim_hold.push_back(c[0]);
      end else if (tag == "I") begin
        n = $fscanf(fd, "%d", c);
        stim_valid.push_back(1'b0);
        stim_op.push_back(2'd0);
        stim_data.push_back(8'h00);
        stim_hold.push_back(c[0]);
      end else if (tag == "E") begin
        n = $fscanf(fd, "%h", b);
        expect_data.push_back(b[7:0]);
      end else if (tag == "D") begin
        n = $fscanf(fd, "%d", b);
        expect_drops = b;
      end else begin
        $display("unknown record in the golden file");
        other_errors++;
      end
    end
    $fclose(fd);
  endtask

  // outputs settle after the rising edge, so look at them on the falling one
  always @(negedge clk) begin
    if (!rst_n) begin
      seq_expect = '0;
    end else begin
      if (out_valid) begin
        got_data.push_back(out_data);
        check_equal("out_seq", int'(out_seq), int'(seq_expect));
        seq_expect = seq_expect + 1'b1;
      end
      if (overflow) begin
        overflow_seen++;
      end
    end
  end

  task automatic check_reset_values();
    check_equal("out_valid in reset", int'(out_valid), 0);
    check_equal("overflow in reset", int'(overflow), 0);
    check_equal("drop_count in reset", int'(drop_count), 0);
    check_equal("out_seq in reset", int'(out_seq), 0);
  endtask

  task automatic replay_stimulus();
    int k;
    for (k = 0; k < stim_valid.size(); k++) begin
      @(posedge clk);
      in_valid <= stim_valid[k];
      in_op    <= stream_pkg::op_e'(stim_op[k]);
      in_data  <= stim_data[k];
      out_hold <= stim_hold[k];
    end
    @(posedge clk);
    in_valid <= 1'b0;
    out_hold <= 1'b0;
  endtask

  task automatic wait_for_outputs(input int count);
    int cycles;
    cycles = 0;
    while (got_data.size() < count && cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    if (got_data.size() < count) begin
      $display("timeout: only %0d of %0d output words arrived", got_data.size(), count);
      timeout_errors++;
    end
  endtask

  task automatic compare_outputs();
    int k;
    check_equal("output word count", got_data.size(), expect_data.size());
    for (k = 0; k < expect_data.size() && k < got_data.size(); k++) begin
      check_equal($sformatf("output word %0d", k), int'(got_data[k]), int'(expect_data[k]));
    end
  endtask

  // one strobe into an empty path, counting edges until out_valid
  task automatic measure_latency();
    int   edges;
    int   base;
    logic seen;
    base = got_data.size();
    edges = 0;
    seen = 1'b0;
    @(posedge clk);
    in_valid <= 1'b1;
    in_op    <= stream_pkg::op_pass;
    in_data  <= 8'hc3;
    out_hold <= 1'b0;
    while (!seen && edges < timeout_cycles) begin
      @(posedge clk);
      in_valid <= 1'b0;
      edges++;
      @(negedge clk);
      seen = out_valid;
    end
    if (!seen) begin
      $display("timeout: the single strobe never reached the output");
      timeout_errors++;
    end else begin
      check_equal("latency in edges", edges, 3);
    end
    @(posedge clk);
    check_equal("single strobe word count", got_data.size() - base, 1);
    if (got_data.size() > base) begin
      check_equal("single strobe word", int'(got_data[base]), 'hc3);
    end
  endtask

  initial begin
    int step;
    rst_n    <= 1'b0;
    in_valid <= 1'b0;
    in_op    <= stream_pkg::op_pass;
    in_data  <= '0;
    out_hold <= 1'b0;
    load_golden();
    for (step = 0; step < 4; step++) begin
      @(posedge clk);
      if (step == 3) begin
        rst_n <= 1'b1;
      end
      @(negedge clk);
      check_reset_values();
    end
    @(posedge clk);
    @(negedge clk);
    check_reset_values();
    replay_stimulus();
    wait_for_outputs(expect_data.size());
    // a few more cycles so that any extra word shows up
    for (step = 0; step < 8; step++) begin
      @(posedge clk);
    end
    @(negedge clk);
    check_equal("drop_count", int'(drop_count), expect_drops);
    check_equal("overflow pulses", overflow_seen, expect_drops);
    compare_outputs();
    measure_latency();
    $display("errors: %0d value, %0d timeout, %0d other",
             value_errors, timeout_errors, other_errors);
    if (value_errors == 0 && timeout_errors == 0 && other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: sim/stream_golden.txt
# S op data hold : one strobe cycle, op 0 pass 1 invert 2 swap, data in hex
# I hold : cycle without strobe ; E data : next output byte in hex ; D n : final drop_count
S 0 a5 0
S 1 a5 0
S 2 1e 0
S 0 00 0
S 1 00 0
S 2 c4 0
S 0 7e 0
S 1 3c 0
S 2 f0 0
S 0 81 0
E a5
E 5a
E e1
E 00
E ff
E 4c
E 7e
E c3
E 0f
E 81
I 0
I 0
I 0
S 0 40 1
S 0 41 1
S 0 42 1
S 0 43 1
S 0 44 1
S 0 45 1
S 0 46 1
S 0 47 1
S 0 48 1
S 0 49 1
S 0 4a 1
S 0 4b 1
S 0 4c 1
S 0 4d 1
S 0 4e 1
S 0 4f 1
S 0 50 1
S 0 51 1
S 0 52 1
S 0 53 1
E 40
E 41
E 42
E 43
E 44
E 45
E 46
E 47
E 48
E 49
E 4a
E 4b
E 4c
E 4d
E 4e
E 4f
E 50
D 3

// File: fwft_stream.f
common/buffer_pkg.sv
common/stream_pkg.sv
sync_fifo/sync_fifo.sv
hdl/word_shaper.sv
hdl/word_drain.sv
hdl/stream_top.sv
sim/stream_properties.sv
sim/stream_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module stream_tb \
  -f fwft_stream.f \
  -o stream_sim

./obj_dir/stream_sim | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
  echo "run_sim: simulation passed"
  exit 0
else
  echo "run_sim: simulation failed"
  exit 1
fi
